// ==== mips_decode_config.svh ====
`ifndef MIPS_DECODE_CONFIG_SVH
`define MIPS_DECODE_CONFIG_SVH

`define DATA_W       32        // data and address width
`define REG_ADDR_W   5         // register number width
`define LINK_REG     31        // link destination
`define LINK_OFFSET  8         // return address past the delay slot

// one-hot ALU control, lui at bit 0
`define ALU_CTRL_W   12
`define ALU_ADD      11
`define ALU_SUB      10
`define ALU_SLT      9
`define ALU_SLTU     8
`define ALU_AND      7
`define ALU_NOR      6
`define ALU_OR       5
`define ALU_XOR      4
`define ALU_SLL      3
`define ALU_SRL      2
`define ALU_SRA      1
`define ALU_LUI      0

`define MEM_CTRL_W   4
`define MEM_LOAD     3         // load at the top
`define MEM_STORE    2
`define MEM_WORD     1         // 1 word, 0 byte
`define MEM_LB_SIGN  0         // signed byte load

`endif

// ==== decode_pkg.sv ====
`include "mips_decode_config.svh"

package decode_pkg;

    // ******************************************************************
    // instruction formats, all 32 bits wide
    // ******************************************************************

    typedef struct packed {
        logic [5:0]             op;     // opcode, zero for SPECIAL
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] sa;     // shift amount
        logic [5:0]             funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]             op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;     // also REGIMM sub-opcode
        logic [15:0]            imm;    // immediate or branch offset
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;            // word index within the 256 MB region
    } j_fmt_t;

    // one fetched word, read through whichever layout the field needs
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } inst_word_t;

endpackage

// ==== decode_ctrl_if.sv ====
`include "mips_decode_config.svh"

interface decode_ctrl_if;

    logic [`ALU_CTRL_W-1:0] alu_control;    // one-hot, see config
    logic imm_zero;         // zero-extended immediate
    logic imm_sign;         // sign-extended immediate
    logic shf_sa;           // shift by sa field
    logic j_link;           // writes return address
    logic wdest_rt;
    logic wdest_31;
    logic wdest_rd;
    logic no_rs;            // rs field not a source
    logic no_rt;            // rt field not a source
    logic load;
    logic store;
    logic ls_word;          // word access
    logic lb_sign;          // signed byte load
    logic jr;               // target from rs_value
    logic j_direct;         // J, JAL
    logic jbr;              // any jump or branch
    logic br_eq;
    logic br_ne;
    logic br_gez;           // also BGEZAL
    logic br_gtz;
    logic br_lez;
    logic br_ltz;           // also BLTZAL

    modport decoder (
        output alu_control, imm_zero, imm_sign, shf_sa, j_link,
               wdest_rt, wdest_31, wdest_rd, no_rs, no_rt,
               load, store, ls_word, lb_sign,
               jr, j_direct, jbr, br_eq, br_ne, br_gez, br_gtz, br_lez, br_ltz
    );

    modport branch (
        input jr, j_direct, br_eq, br_ne, br_gez, br_gtz, br_lez, br_ltz
    );

    modport hazard (input no_rs, no_rt, jbr);

    modport operands (
        input imm_zero, imm_sign, shf_sa, j_link,
              wdest_rt, wdest_31, wdest_rd, load, store, ls_word, lb_sign
    );

endinterface

// ==== inst_decoder.sv ====
`include "mips_decode_config.svh"

module inst_decoder (
    input  decode_pkg::inst_word_t inst,
    decode_ctrl_if.decoder         ctrl
);

    logic op_zero, sa_zero, rs_zero, rt_zero, rd_zero, rd_link;
    logic is_addu, is_subu, is_slt, is_sltu, is_and, is_nor, is_or, is_xor;
    logic is_sll, is_srl, is_sra, is_sllv, is_srlv, is_srav, is_jr, is_jalr;
    logic is_addiu, is_slti, is_sltiu, is_andi, is_ori, is_xori, is_lui;
    logic is_lw, is_lb, is_lbu, is_sw, is_sb;
    logic is_j, is_jal, is_beq, is_bne, is_bgez, is_bgtz, is_blez, is_bltz;
    logic is_bgezal, is_bltzal;

    assign op_zero = (inst.r.op == 6'd0);                   // SPECIAL
    assign sa_zero = (inst.r.sa == '0);
    assign rs_zero = (inst.r.rs == '0);
    assign rt_zero = (inst.r.rt == '0);
    assign rd_zero = (inst.r.rd == '0);
    assign rd_link = (inst.r.rd == `REG_ADDR_W'(`LINK_REG));

    // ******************************************************************
    // SPECIAL group, funct decoded with reserved fields checked
    // ******************************************************************
    assign is_addu = op_zero & sa_zero & (inst.r.funct == 6'b100001);
    assign is_subu = op_zero & sa_zero & (inst.r.funct == 6'b100011);
    assign is_slt  = op_zero & sa_zero & (inst.r.funct == 6'b101010);
    assign is_sltu = op_zero & sa_zero & (inst.r.funct == 6'b101011);
    assign is_and  = op_zero & sa_zero & (inst.r.funct == 6'b100100);
    assign is_nor  = op_zero & sa_zero & (inst.r.funct == 6'b100111);
    assign is_or   = op_zero & sa_zero & (inst.r.funct == 6'b100101);
    assign is_xor  = op_zero & sa_zero & (inst.r.funct == 6'b100110);
    assign is_sll  = op_zero & rs_zero & (inst.r.funct == 6'b000000);   // sa form
    assign is_srl  = op_zero & rs_zero & (inst.r.funct == 6'b000010);
    assign is_sra  = op_zero & rs_zero & (inst.r.funct == 6'b000011);
    assign is_sllv = op_zero & sa_zero & (inst.r.funct == 6'b000100);
    assign is_srlv = op_zero & sa_zero & (inst.r.funct == 6'b000110);
    assign is_srav = op_zero & sa_zero & (inst.r.funct == 6'b000111);
    assign is_jr   = op_zero & rt_zero & rd_zero & sa_zero & (inst.r.funct == 6'b001000);
    assign is_jalr = op_zero & rt_zero & rd_link & sa_zero & (inst.r.funct == 6'b001001);

    // ******************************************************************
    // immediate, memory and jump opcodes
    // ******************************************************************
    assign is_addiu = (inst.i.op == 6'b001001);
    assign is_slti  = (inst.i.op == 6'b001010);
    assign is_sltiu = (inst.i.op == 6'b001011);
    assign is_andi  = (inst.i.op == 6'b001100);
    assign is_ori   = (inst.i.op == 6'b001101);
    assign is_xori  = (inst.i.op == 6'b001110);
    assign is_lui   = (inst.i.op == 6'b001111) & rs_zero;
    assign is_lw    = (inst.i.op == 6'b100011);
    assign is_lb    = (inst.i.op == 6'b100000);
    assign is_lbu   = (inst.i.op == 6'b100100);
    assign is_sw    = (inst.i.op == 6'b101011);
    assign is_sb    = (inst.i.op == 6'b101000);
    assign is_j     = (inst.j.op == 6'b000010);
    assign is_jal   = (inst.j.op == 6'b000011);
    assign is_beq   = (inst.i.op == 6'b000100);
    assign is_bne   = (inst.i.op == 6'b000101);
    assign is_blez  = (inst.i.op == 6'b000110) & rt_zero;
    assign is_bgtz  = (inst.i.op == 6'b000111) & rt_zero;
    // REGIMM, sub-opcode in rt
    assign is_bltz   = (inst.i.op == 6'b000001) & (inst.i.rt == 5'b00000);
    assign is_bgez   = (inst.i.op == 6'b000001) & (inst.i.rt == 5'b00001);
    assign is_bltzal = (inst.i.op == 6'b000001) & (inst.i.rt == 5'b10000);
    assign is_bgezal = (inst.i.op == 6'b000001) & (inst.i.rt == 5'b10001);

    // ******************************************************************
    // class flags
    // ******************************************************************
    assign ctrl.load     = is_lw | is_lb | is_lbu;
    assign ctrl.store    = is_sw | is_sb;
    assign ctrl.ls_word  = is_lw | is_sw;
    assign ctrl.lb_sign  = is_lb;
    assign ctrl.j_link   = is_jal | is_jalr | is_bgezal | is_bltzal;
    assign ctrl.shf_sa   = is_sll | is_srl | is_sra;
    assign ctrl.imm_zero = is_andi | is_ori | is_xori | is_lui;
    assign ctrl.imm_sign = is_addiu | is_slti | is_sltiu | ctrl.load | ctrl.store;

    assign ctrl.wdest_rt = ctrl.imm_zero | is_addiu | is_slti | is_sltiu | ctrl.load;
    assign ctrl.wdest_31 = is_jal | is_bgezal | is_bltzal;
    assign ctrl.wdest_rd = is_addu | is_subu | is_slt | is_sltu | is_and | is_nor
                         | is_or | is_xor | is_sll | is_srl | is_sra
                         | is_sllv | is_srlv | is_srav | is_jalr;

    assign ctrl.no_rs = is_j | is_jal | ctrl.shf_sa | is_lui;  // field is not rs
    assign ctrl.no_rt = ctrl.imm_zero | is_addiu | is_slti | is_sltiu | ctrl.load
                      | is_j | is_jal | is_jr | is_jalr
                      | is_bgez | is_bgtz | is_blez | is_bltz | is_bgezal | is_bltzal;

    assign ctrl.jr       = is_jr | is_jalr;
    assign ctrl.j_direct = is_j | is_jal;
    assign ctrl.br_eq    = is_beq;
    assign ctrl.br_ne    = is_bne;
    assign ctrl.br_gez   = is_bgez | is_bgezal;
    assign ctrl.br_gtz   = is_bgtz;
    assign ctrl.br_lez   = is_blez;
    assign ctrl.br_ltz   = is_bltz | is_bltzal;
    assign ctrl.jbr      = ctrl.jr | ctrl.j_direct | is_beq | is_bne | ctrl.br_gez
                         | is_bgtz | is_blez | ctrl.br_ltz;

    always_comb begin
        ctrl.alu_control = '0;
        ctrl.alu_control[`ALU_ADD]  = is_addu | is_addiu | ctrl.load | ctrl.store
                                    | ctrl.j_link;      // address and link adds
        ctrl.alu_control[`ALU_SUB]  = is_subu;
        ctrl.alu_control[`ALU_SLT]  = is_slt | is_slti;
        ctrl.alu_control[`ALU_SLTU] = is_sltu | is_sltiu;
        ctrl.alu_control[`ALU_AND]  = is_and | is_andi;
        ctrl.alu_control[`ALU_NOR]  = is_nor;
        ctrl.alu_control[`ALU_OR]   = is_or | is_ori;
        ctrl.alu_control[`ALU_XOR]  = is_xor | is_xori;
        ctrl.alu_control[`ALU_SLL]  = is_sll | is_sllv;
        ctrl.alu_control[`ALU_SRL]  = is_srl | is_srlv;
        ctrl.alu_control[`ALU_SRA]  = is_sra | is_srav;
        ctrl.alu_control[`ALU_LUI]  = is_lui;
    end

endmodule

// ==== branch_unit.sv ====
`include "mips_decode_config.svh"

module branch_unit (
    input  decode_pkg::inst_word_t  inst,
    decode_ctrl_if.branch           ctrl,
    input  logic [`DATA_W-1:0]      pc,
    input  logic [`DATA_W-1:0]      rs_value,
    input  logic [`DATA_W-1:0]      rt_value,
    input  logic                    id_over,
    output logic                    jbr_taken,
    output logic [`DATA_W-1:0]      jbr_target
);

    logic [`DATA_W-1:0] bd_pc;          // delay slot pc
    logic [`DATA_W-1:0] j_target;
    logic [`DATA_W-1:0] br_target;
    logic [`DATA_W-1:0] br_offset;
    logic               j_taken;
    logic               br_taken;
    logic               rs_eq_rt;
    logic               rs_ez;
    logic               rs_ltz;

    assign bd_pc = pc + `DATA_W'(4);

    // ******************************************************************
    // jumps
    // ******************************************************************
    assign j_taken  = ctrl.jr | ctrl.j_direct;
    assign j_target = ctrl.jr ? rs_value
                              : {bd_pc[`DATA_W-1 -: 4], inst.j.target, 2'b00};

    // ******************************************************************
    // branches, relative to the delay slot
    // ******************************************************************
    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_ez    = (rs_value == '0);
    assign rs_ltz   = rs_value[`DATA_W-1];      // sign bit

    assign br_taken = ctrl.br_eq  & rs_eq_rt
                    | ctrl.br_ne  & ~rs_eq_rt
                    | ctrl.br_gez & ~rs_ltz
                    | ctrl.br_gtz & ~rs_ltz & ~rs_ez
                    | ctrl.br_lez & (rs_ltz | rs_ez)
                    | ctrl.br_ltz & rs_ltz;

    assign br_offset = {{(`DATA_W-18){inst.i.imm[15]}}, inst.i.imm, 2'b00};  // offset x4
    assign br_target = bd_pc + br_offset;

    // no redirect until the stage completes
    assign jbr_taken  = (j_taken | br_taken) & id_over;
    assign jbr_target = j_taken ? j_target : br_target;

endmodule

// ==== hazard_check.sv ====
`include "mips_decode_config.svh"

module hazard_check (
    input  decode_pkg::inst_word_t    inst,
    decode_ctrl_if.hazard             ctrl,
    input  logic                      id_valid,
    input  logic                      if_over,
    input  logic [`REG_ADDR_W-1:0]    exe_wdest,
    input  logic [`REG_ADDR_W-1:0]    mem_wdest,
    input  logic [`REG_ADDR_W-1:0]    wb_wdest,
    output logic                      id_over
);

    logic rs_wait;
    logic rt_wait;

    // register 0 never creates a dependency
    assign rs_wait = ~ctrl.no_rs & (inst.r.rs != '0)
                   & ((inst.r.rs == exe_wdest)
                   |  (inst.r.rs == mem_wdest)
                   |  (inst.r.rs == wb_wdest));

    assign rt_wait = ~ctrl.no_rt & (inst.r.rt != '0)
                   & ((inst.r.rt == exe_wdest)
                   |  (inst.r.rt == mem_wdest)
                   |  (inst.r.rt == wb_wdest));

    // a jump or branch must wait for fetch to finish, or its redirect
    // would arrive after the next pc has already been latched
    assign id_over = id_valid & ~rs_wait & ~rt_wait & (~ctrl.jbr | if_over);

endmodule

// ==== operand_select.sv ====
`include "mips_decode_config.svh"

module operand_select (
    input  decode_pkg::inst_word_t    inst,
    decode_ctrl_if.operands           ctrl,
    input  logic [`DATA_W-1:0]        pc,
    input  logic [`DATA_W-1:0]        rs_value,
    input  logic [`DATA_W-1:0]        rt_value,
    output logic [`DATA_W-1:0]        alu_operand1,
    output logic [`DATA_W-1:0]        alu_operand2,
    output logic [`DATA_W-1:0]        store_data,
    output logic [`MEM_CTRL_W-1:0]    mem_control,
    output logic                      rf_wen,
    output logic [`REG_ADDR_W-1:0]    rf_wdest
);

    logic [`DATA_W-1:0] sa_ext;
    logic [`DATA_W-1:0] imm_zext;
    logic [`DATA_W-1:0] imm_sext;

    assign sa_ext   = {{(`DATA_W-`REG_ADDR_W){1'b0}}, inst.r.sa};
    assign imm_zext = {{(`DATA_W-16){1'b0}}, inst.i.imm};
    assign imm_sext = {{(`DATA_W-16){inst.i.imm[15]}}, inst.i.imm};

    // ******************************************************************
    // ALU operands
    // ******************************************************************
    // link computes pc + 8 in the ALU, past the delay slot
    assign alu_operand1 = ctrl.j_link ? pc
                        : ctrl.shf_sa ? sa_ext
                        : rs_value;

    assign alu_operand2 = ctrl.j_link   ? `DATA_W'(`LINK_OFFSET)
                        : ctrl.imm_zero ? imm_zext
                        : ctrl.imm_sign ? imm_sext
                        : rt_value;

    // ******************************************************************
    // memory and write-back
    // ******************************************************************
    always_comb begin
        mem_control = '0;
        mem_control[`MEM_LOAD]    = ctrl.load;
        mem_control[`MEM_STORE]   = ctrl.store;
        mem_control[`MEM_WORD]    = ctrl.ls_word;
        mem_control[`MEM_LB_SIGN] = ctrl.lb_sign;
    end

    assign store_data = rt_value;

    assign rf_wen   = ctrl.wdest_rt | ctrl.wdest_31 | ctrl.wdest_rd;
    assign rf_wdest = ctrl.wdest_rt ? inst.i.rt
                    : ctrl.wdest_31 ? `REG_ADDR_W'(`LINK_REG)
                    : ctrl.wdest_rd ? inst.r.rd
                    : '0;               // zero keeps hazard compares quiet

endmodule

// ==== decode_stage.sv ====
`include "mips_decode_config.svh"

module decode_stage (
    input  logic                      id_valid,
    input  logic                      if_over,
    input  logic [`DATA_W-1:0]        if_inst,
    input  logic [`DATA_W-1:0]        if_pc,
    input  logic [`DATA_W-1:0]        rs_value,
    input  logic [`DATA_W-1:0]        rt_value,
    input  logic [`REG_ADDR_W-1:0]    exe_wdest,
    input  logic [`REG_ADDR_W-1:0]    mem_wdest,
    input  logic [`REG_ADDR_W-1:0]    wb_wdest,
    output logic [`REG_ADDR_W-1:0]    rs,
    output logic [`REG_ADDR_W-1:0]    rt,
    output logic                      jbr_taken,
    output logic [`DATA_W-1:0]        jbr_target,
    output logic                      id_over,
    output logic [`ALU_CTRL_W-1:0]    alu_control,
    output logic [`DATA_W-1:0]        alu_operand1,
    output logic [`DATA_W-1:0]        alu_operand2,
    output logic [`DATA_W-1:0]        store_data,
    output logic [`MEM_CTRL_W-1:0]    mem_control,
    output logic                      rf_wen,
    output logic [`REG_ADDR_W-1:0]    rf_wdest,
    output logic [`DATA_W-1:0]        id_pc
);

    import decode_pkg::*;

    inst_word_t inst;

    decode_ctrl_if ctrl ();

    assign inst        = if_inst;
    assign rs          = inst.r.rs;         // register file read addresses
    assign rt          = inst.r.rt;
    assign alu_control = ctrl.alu_control;
    assign id_pc       = if_pc;

    // ******************************************************************
    // peers, all fed by the one decoder
    // ******************************************************************
    inst_decoder i_inst_decoder (
        .inst (inst),
        .ctrl (ctrl.decoder)
    );

    branch_unit i_branch_unit (
        .inst       (inst),
        .ctrl       (ctrl.branch),
        .pc         (if_pc),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .id_over    (id_over),
        .jbr_taken  (jbr_taken),
        .jbr_target (jbr_target)
    );

    hazard_check i_hazard_check (
        .inst      (inst),
        .ctrl      (ctrl.hazard),
        .id_valid  (id_valid),
        .if_over   (if_over),
        .exe_wdest (exe_wdest),
        .mem_wdest (mem_wdest),
        .wb_wdest  (wb_wdest),
        .id_over   (id_over)
    );

    operand_select i_operand_select (
        .inst         (inst),
        .ctrl         (ctrl.operands),
        .pc           (if_pc),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .alu_operand1 (alu_operand1),
        .alu_operand2 (alu_operand2),
        .store_data   (store_data),
        .mem_control  (mem_control),
        .rf_wen       (rf_wen),
        .rf_wdest     (rf_wdest)
    );

endmodule

// ==== tb_decode_stage.sv ====
`include "mips_decode_config.svh"

module tb_decode_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_VEC  = 2000;
    localparam int PERIOD = 4;
    localparam int BAD    = 38;     // kind number of an unsupported word

    // instruction kinds 0..15 are SPECIAL, 16..37 have their own opcode
    localparam logic [5:0] SPECIAL_FUNCT [16] = '{
        6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h27, 6'h25, 6'h26,
        6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09
    };

    localparam logic [5:0] OPCODE [22] = '{
        6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h23,
        6'h20, 6'h24, 6'h2b, 6'h28, 6'h02, 6'h03, 6'h04, 6'h05,
        6'h06, 6'h07, 6'h01, 6'h01, 6'h01, 6'h01   // REGIMM for the last four
    };

    typedef struct packed {
        logic        over;
        logic        taken;
        logic        jbr;           // target is only meaningful here
        logic [31:0] target;
        logic [11:0] alu;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [3:0]  mem;
        logic        wen;
        logic [4:0]  wdest;
        logic [31:0] sdata;
        logic [4:0]  rs_a;
        logic [4:0]  rt_a;
        logic [31:0] pc;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        id_valid, if_over;
    logic [31:0] if_inst, if_pc, rs_value, rt_value;
    logic [4:0]  exe_wdest, mem_wdest, wb_wdest;
    logic [4:0]  rs, rt, rf_wdest;
    logic        jbr_taken, id_over, rf_wen;
    logic [31:0] jbr_target, alu_operand1, alu_operand2, store_data, id_pc;
    logic [11:0] alu_control;
    logic [3:0]  mem_control;

    logic [31:0] rng_state = 32'hfc85_de1a;
    expect_t     exp_q;
    logic        check_en = 1'b0;
    int          errors = 0;

    decode_stage i_decode_stage (.*);

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic int alu_bit(input int kind);
        case (kind)
            0, 15, 16, 23, 24, 25, 26, 27, 29, 36, 37: return `ALU_ADD;
            1: return `ALU_SUB;
            2, 17: return `ALU_SLT;
            3, 18: return `ALU_SLTU;
            4, 19: return `ALU_AND;
            5: return `ALU_NOR;
            6, 20: return `ALU_OR;
            7, 21: return `ALU_XOR;
            8, 11: return `ALU_SLL;
            9, 12: return `ALU_SRL;
            10, 13: return `ALU_SRA;
            22: return `ALU_LUI;
            default: return -1;            // no ALU work
        endcase
    endfunction

    function automatic logic [31:0] encode(input int kind, input logic [31:0] r);
        logic [31:0] w;
        w = r;
        if (kind <= 15) begin
            w[31:26] = 6'h00;
            w[5:0]   = SPECIAL_FUNCT[kind];
            if (kind inside {[8:10]}) w[25:21] = 5'd0;
            else w[10:6] = 5'd0;
            if (kind >= 14) w[20:16] = 5'd0;
            if (kind == 14) w[15:11] = 5'd0;
            if (kind == 15) w[15:11] = 5'd31;   // JALR needs rd 31
        end else if (kind == BAD) begin
            w[31:26] = {2'b01, r[3:0]};         // opcodes 0x10..0x1f are never kept
        end else begin
            w[31:26] = OPCODE[kind - 16];
            case (kind)
                22: w[25:21] = 5'd0;
                32, 33, 34: w[20:16] = 5'd0;
                35: w[20:16] = 5'd1;
                36: w[20:16] = 5'd16;
                37: w[20:16] = 5'd17;
                default: ;
            endcase
        end
        return w;
    endfunction

    // ******************************************************************
    // reference model
    // ******************************************************************
    function automatic expect_t model(input int kind, input logic [31:0] w,
                                      input logic [31:0] pc, input logic [31:0] rsv,
                                      input logic [31:0] rtv, input logic [4:0] ewd,
                                      input logic [4:0] mwd, input logic [4:0] wwd,
                                      input logic valid, input logic ifo);
        expect_t     e;
        logic [4:0]  rs_f, rt_f;
        logic [31:0] bd;
        logic        link, shf, zimm, simm, ld, st, cond, use_rs, use_rt, rs_hit, rt_hit;
        int          ab;
        rs_f   = w[25:21];
        rt_f   = w[20:16];
        bd     = pc + 32'd4;
        link   = kind inside {15, 29, 36, 37};
        shf    = kind inside {[8:10]};
        zimm   = kind inside {[19:22]};
        simm   = kind inside {[16:18], [23:27]};
        ld     = kind inside {[23:25]};
        st     = kind inside {26, 27};
        // an unmatched word clears both no-source flags
        use_rs = !(kind inside {8, 9, 10, 22, 28, 29});
        use_rt = kind inside {[0:13], 26, 27, 30, 31, BAD};
        case (kind)
            14, 15, 28, 29: cond = 1'b1;
            30: cond = (rsv == rtv);
            31: cond = (rsv != rtv);
            32: cond = ($signed(rsv) <= 0);
            33: cond = ($signed(rsv) > 0);
            34, 36: cond = ($signed(rsv) < 0);
            35, 37: cond = ($signed(rsv) >= 0);
            default: cond = 1'b0;
        endcase
        rs_hit = use_rs && rs_f != 5'd0 && (rs_f == ewd || rs_f == mwd || rs_f == wwd);
        rt_hit = use_rt && rt_f != 5'd0 && (rt_f == ewd || rt_f == mwd || rt_f == wwd);
        e.jbr   = kind inside {14, 15, [28:37]};
        e.over  = valid && !rs_hit && !rt_hit && (!e.jbr || ifo);
        e.taken = e.over && cond;
        if (kind inside {14, 15}) e.target = rsv;
        else if (kind inside {28, 29}) e.target = {bd[31:28], w[25:0], 2'b00};
        else e.target = bd + {{14{w[15]}}, w[15:0], 2'b00};
        ab = alu_bit(kind);
        e.alu = (ab >= 0) ? (12'd1 << ab) : 12'd0;
        e.op1 = link ? pc : shf ? {27'd0, w[10:6]} : rsv;
        e.op2 = link ? 32'd8 : zimm ? {16'd0, w[15:0]}
              : simm ? {{16{w[15]}}, w[15:0]} : rtv;
        e.mem = {ld, st, kind == 23 || kind == 26, kind == 24};
        if (kind inside {[16:25]}) e.wdest = rt_f;
        else if (kind inside {29, 36, 37}) e.wdest = 5'd31;
        else if (kind inside {[0:13], 15}) e.wdest = w[15:11];
        else e.wdest = 5'd0;
        e.wen   = (kind inside {[0:13], [15:25], 29, 36, 37});
        e.sdata = rtv;
        e.rs_a  = rs_f;
        e.rt_a  = rt_f;
        e.pc    = pc;
        return e;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("ERR %0t %s expected %h actual %h", $time, name, expv, actv);
        errors++;
    endtask

    // checked at the edge after the inputs were driven
    always @(posedge clk) begin
        if (check_en && !rst) begin
            a_over: assert (id_over === exp_q.over)
                else report_mismatch("id_over", 32'(exp_q.over), 32'(id_over));
            a_taken: assert (jbr_taken === exp_q.taken)
                else report_mismatch("jbr_taken", 32'(exp_q.taken), 32'(jbr_taken));
            a_target: assert (!exp_q.jbr || jbr_target === exp_q.target)
                else report_mismatch("jbr_target", exp_q.target, jbr_target);
            a_alu: assert (alu_control === exp_q.alu)
                else report_mismatch("alu_control", 32'(exp_q.alu), 32'(alu_control));
            a_op1: assert (alu_operand1 === exp_q.op1)
                else report_mismatch("alu_operand1", exp_q.op1, alu_operand1);
            a_op2: assert (alu_operand2 === exp_q.op2)
                else report_mismatch("alu_operand2", exp_q.op2, alu_operand2);
            a_mem: assert (mem_control === exp_q.mem)
                else report_mismatch("mem_control", 32'(exp_q.mem), 32'(mem_control));
            a_wen: assert (rf_wen === exp_q.wen)
                else report_mismatch("rf_wen", 32'(exp_q.wen), 32'(rf_wen));
            a_wdest: assert (rf_wdest === exp_q.wdest)
                else report_mismatch("rf_wdest", 32'(exp_q.wdest), 32'(rf_wdest));
            a_sdata: assert (store_data === exp_q.sdata)
                else report_mismatch("store_data", exp_q.sdata, store_data);
            a_rs: assert (rs === exp_q.rs_a)
                else report_mismatch("rs", 32'(exp_q.rs_a), 32'(rs));
            a_rt: assert (rt === exp_q.rt_a)
                else report_mismatch("rt", 32'(exp_q.rt_a), 32'(rt));
            a_pc: assert (id_pc === exp_q.pc)
                else report_mismatch("id_pc", exp_q.pc, id_pc);
        end
    end

    initial begin
        #(N_VEC * PERIOD + 200);
        $display("timeout: the stimulus did not finish in time");
        $display("Regression failed");
        $finish;
    end

    initial begin
        int          kind;
        logic [31:0] w, pc, rsv, rtv, r;
        logic [4:0]  wd [3];
        logic        valid, ifo;
        rst = 1'b1;
        id_valid = 1'b0;
        if_over = 1'b0;
        if_inst = '0;
        if_pc = '0;
        rs_value = '0;
        rt_value = '0;
        exe_wdest = '0;
        mem_wdest = '0;
        wb_wdest = '0;
        exp_q = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < N_VEC; n++) begin
            @(posedge clk);
            r = next_rand();
            kind = (r % 100 < 5) ? BAD : int'(next_rand() % 38);
            w   = encode(kind, next_rand());
            r   = next_rand();
            pc  = {r[31:2], 2'b00};
            rsv = next_rand();
            r   = next_rand();
            rtv = (r[1:0] == 2'b00) ? rsv : next_rand();   // equal often for BEQ/BNE
            if (r[2]) rsv = {rsv[31], 31'd0};                // zero or bare sign
            for (int k = 0; k < 3; k++) begin
                r = next_rand();
                wd[k] = (r[1:0] == 2'd0) ? w[25:21] : (r[1:0] == 2'd1) ? w[20:16] : r[8:4];
            end
            r = next_rand();
            valid = (r[2:0] != 3'd0);
            ifo   = (r[4:3] != 2'd0);
            if_inst   <= w;
            if_pc     <= pc;
            rs_value  <= rsv;
            rt_value  <= rtv;
            exe_wdest <= wd[0];
            mem_wdest <= wd[1];
            wb_wdest  <= wd[2];
            id_valid  <= valid;
            if_over   <= ifo;
            exp_q     <= model(kind, w, pc, rsv, rtv, wd[0], wd[1], wd[2], valid, ifo);
            check_en  <= 1'b1;
        end
        @(posedge clk);
        check_en <= 1'b0;
        @(posedge clk);
        $display("vectors %0d, errors %0d", N_VEC, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
decode_pkg.sv
decode_ctrl_if.sv
inst_decoder.sv
branch_unit.sv
hazard_check.sv
operand_select.sv
decode_stage.sv
tb_decode_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_decode_stage
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard *.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(BUILD_DIR)
